// File: src/rx_pkg.sv
/* Shared definitions of the receive path: settings map, bus and stream types,
   and the state encodings. Modules import it inside their bodies. */
`default_nettype none

package rx_pkg;

   //////////////////////////////////////////////////
   // Settings bus
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   localparam int SR_TIME64  = 10;   // +0 high word, +1 low word
   localparam int SR_RX_CTRL = 32;

   typedef enum logic [SET_ADDR_W-1:0] {
      RX_CMD   = 8'd0,   // Burst length, a write starts the burst
      RX_DECIM = 8'd1,
      RX_SPP   = 8'd2,
      RX_CLEAR = 8'd3    // Strobe only
   } rx_setting_e;

   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   // True in the cycle a register at addr is written
   function automatic logic set_hit(set_bus_t s, int unsigned addr);
      return s.stb && (s.addr == SET_ADDR_W'(addr));
   endfunction

   //////////////////////////////////////////////////
   // Samples, time and lines
   localparam int TIME_W  = 64;
   localparam int ADC_W   = 14;
   localparam int HALF_W  = 16;   // One sign-extended ADC channel
   localparam int LINE_W  = 34;
   localparam int FIFO_AW = 4;
   localparam int FIFO_DEPTH = 1 << FIFO_AW;

   localparam logic [HALF_W-1:0] SPP_RESET = 16'd16;

   typedef logic [TIME_W-1:0]   vita_time_t;
   typedef logic [2*HALF_W-1:0] sample_t;   // {adc_a, adc_b}

   typedef struct packed {
      sample_t    data;
      vita_time_t ts;
      logic       last;   // Final sample of a burst
   } stream_item_t;

   typedef struct packed {
      logic              sof;
      logic              eof;
      logic [LINE_W-3:0] data;
   } line_t;

   //////////////////////////////////////////////////
   // State encodings
   typedef enum logic [2:0] {IDLE, HEADER, TIME_HI, TIME_LO, SAMPLE, WAIT_ACK} framer_state_e;

   typedef enum logic [1:0] {HS_IDLE, HS_LOAD, HS_REQ, HS_REL} hs_phase_e;

endpackage

`default_nettype wire

// File: src/rx_stream_if.sv
/* Four-phase sample stream between the receive blocks. The sender raises req
   over a stable item, the receiver answers with ack. */
`default_nettype none

interface rx_stream_if;
   import rx_pkg::*;

   logic         req;    // From sender
   logic         ack;    // From receiver
   stream_item_t item;

   modport sender (
      output req,
      output item,
      input  ack
   );

   modport receiver (
      input  req,
      input  item,
      output ack
   );

endinterface

`default_nettype wire

// File: src/vita_timer.sv
/* 64-bit VITA time counter on the DSP clock. Software loads it with two
   settings writes, high word first, the low word write takes effect. */
`default_nettype none

module vita_timer (
   input  wire logic              dsp_clk,
   input  wire logic              por_rst,
   input  wire rx_pkg::set_bus_t  set_i,
   output rx_pkg::vita_time_t     vita_time_o
);
   import rx_pkg::*;

   logic [SET_DATA_W-1:0] hi_stage;   // Waits for the low word
   logic                  wr_hi;
   logic                  wr_lo;

   assign wr_hi = set_hit(set_i, SR_TIME64 + 0);
   assign wr_lo = set_hit(set_i, SR_TIME64 + 1);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         hi_stage <= '0;
      end else if (wr_hi) begin
         hi_stage <= set_i.data;
      end
   end

   // Both words land together so the time is never torn
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o <= '0;
      end else if (wr_lo) begin
         vita_time_o <= {hi_stage, set_i.data};
      end else begin
         vita_time_o <= vita_time_o + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: src/rx_sample_capture.sv
/* ADC capture stage. Runs a burst of RX_CMD samples, one every RX_DECIM+1 clocks,
   stamps each with VITA time and offers it on the stream. Flags overruns. */
`default_nettype none

module rx_sample_capture (
   input  wire logic                     dsp_clk,
   input  wire logic                     por_rst,
   input  wire rx_pkg::set_bus_t         set_i,
   input  wire logic [rx_pkg::ADC_W-1:0] adc_a_i,
   input  wire logic [rx_pkg::ADC_W-1:0] adc_b_i,
   input  wire rx_pkg::vita_time_t       vita_time_i,
   rx_stream_if.sender                   out,
   output logic                          run_o,
   output logic                          overrun_o
);
   import rx_pkg::*;

   logic [HALF_W-1:0]     decim_q;
   logic [HALF_W-1:0]     dec_cnt;   // Clocks to next strobe
   logic [SET_DATA_W-1:0] remain;    // Strobes left in burst
   hs_phase_e             ph;
   stream_item_t          item_q;
   sample_t               smp;
   logic                  cmd_wr;
   logic                  clr_wr;
   logic                  strobe;
   logic                  busy;

   assign cmd_wr = set_hit(set_i, SR_RX_CTRL + RX_CMD) && (set_i.data != '0);
   assign clr_wr = set_hit(set_i, SR_RX_CTRL + RX_CLEAR);
   assign strobe = run_o && (dec_cnt == '0);
   assign busy   = (ph == HS_LOAD) || (ph == HS_REQ);   // Previous item not yet taken

   assign smp = {{(HALF_W-ADC_W){adc_a_i[ADC_W-1]}}, adc_a_i,
                 {(HALF_W-ADC_W){adc_b_i[ADC_W-1]}}, adc_b_i};

   assign out.req  = (ph == HS_REQ);
   assign out.item = item_q;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         decim_q <= '0;
      end else if (set_hit(set_i, SR_RX_CTRL + RX_DECIM)) begin
         decim_q <= set_i.data[HALF_W-1:0];
      end
   end

   //////////////////////////////////////////////////
   // Burst control and sending handshake
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         run_o     <= 1'b0;
         overrun_o <= 1'b0;
         dec_cnt   <= '0;
         remain    <= '0;
         ph        <= HS_IDLE;
      end else begin
         case (ph)
            HS_LOAD: if (!out.ack) ph <= HS_REQ;    // New req only once ack is low
            HS_REQ:  if (out.ack) ph <= HS_REL;
            HS_REL:  if (!out.ack) ph <= HS_IDLE;
            default: ;
         endcase

         if (strobe) begin
            dec_cnt <= decim_q;
            remain  <= remain - 1'b1;
            if (remain == 1) run_o <= 1'b0;
            if (busy) begin
               overrun_o <= 1'b1;   // Sample dropped, burst stops
               run_o     <= 1'b0;
            end else begin
               ph <= HS_LOAD;
            end
         end else if (run_o) begin
            dec_cnt <= dec_cnt - 1'b1;
         end

         if (cmd_wr) begin
            run_o     <= 1'b1;
            overrun_o <= 1'b0;
            remain    <= set_i.data;
            dec_cnt   <= '0;     // First strobe on the next edge
         end
         if (clr_wr) begin
            run_o     <= 1'b0;
            overrun_o <= 1'b0;
         end
      end
   end

   // Sample register
   always_ff @(posedge dsp_clk) begin
      if (strobe && !busy) begin
         item_q.data <= smp;
         item_q.ts   <= vita_time_i;
         item_q.last <= (remain == 1);
      end else if (strobe) begin
         // On overrun the item still waiting for ack ends the burst
         item_q.last <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: src/rx_sample_fifo.sv
/* 16-entry sample FIFO between capture and framer. Accepts on the ack edge of
   the write side and offers its head on a four-phase read side. */
`default_nettype none

module rx_sample_fifo (
   input  wire logic             dsp_clk,
   input  wire logic             por_rst,
   input  wire rx_pkg::set_bus_t set_i,
   rx_stream_if.receiver         in,
   rx_stream_if.sender           out
);
   import rx_pkg::*;

   stream_item_t     mem [FIFO_DEPTH];
   stream_item_t     head_q;
   logic [FIFO_AW:0] wr_ptr;
   logic [FIFO_AW:0] rd_ptr;   // Head stays counted until its ack
   hs_phase_e        rd_ph;
   logic             in_ack;
   logic             full;
   logic             empty;
   logic             push;
   logic             rd_busy;
   logic             clr_wr;

   assign clr_wr  = set_hit(set_i, SR_RX_CTRL + RX_CLEAR);
   assign empty   = (wr_ptr == rd_ptr);
   assign full    = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                    (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
   assign push    = in.req && !in_ack && !full;   // Ack held back while full
   assign rd_busy = (rd_ph == HS_REQ);

   assign in.ack   = in_ack;
   assign out.req  = rd_busy;
   assign out.item = head_q;

   always_ff @(posedge dsp_clk) begin
      if (push) mem[wr_ptr[FIFO_AW-1:0]] <= in.item;
   end

   //////////////////////////////////////////////////
   // Write side, acknowledging
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         in_ack <= 1'b0;
         wr_ptr <= '0;
      end else begin
         if (push) begin
            in_ack <= 1'b1;
            wr_ptr <= wr_ptr + 1'b1;
         end else if (in_ack && !in.req) begin
            in_ack <= 1'b0;
         end
         // Empty out, but keep the head that is already on offer
         if (clr_wr) wr_ptr <= rd_ptr + {{FIFO_AW{1'b0}}, rd_busy};
      end
   end

   //////////////////////////////////////////////////
   // Read side, sending
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rd_ph  <= HS_IDLE;
         rd_ptr <= '0;
      end else begin
         case (rd_ph)
            HS_IDLE: if (!empty && !clr_wr) rd_ph <= HS_REQ;
            HS_REQ: begin
               if (out.ack) begin
                  rd_ptr <= rd_ptr + 1'b1;   // Pop on ack
                  rd_ph  <= HS_REL;
               end
            end
            HS_REL:  if (!out.ack) rd_ph <= HS_IDLE;
            default: rd_ph <= HS_IDLE;
         endcase
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (rd_ph == HS_IDLE) head_q <= mem[rd_ptr[FIFO_AW-1:0]];
   end

endmodule

`default_nettype wire

// File: src/rx_vita_framer.sv
/* VITA packet framer. Turns stream items into header, time and sample lines,
   each sent as one four-phase transfer on the line output. */
`default_nettype none

module rx_vita_framer (
   input  wire logic             dsp_clk,
   input  wire logic             por_rst,
   input  wire rx_pkg::set_bus_t set_i,
   rx_stream_if.receiver         in,
   output rx_pkg::line_t         line_o,
   output logic                  line_req_o,
   input  wire logic             line_ack_i
);
   import rx_pkg::*;

   logic [HALF_W-1:0] spp_q;
   logic [HALF_W-1:0] seq_q;
   logic [HALF_W-1:0] pkt_cnt;   // Samples sent in this packet
   framer_state_e     state;
   hs_phase_e         line_ph;
   line_t             next_line;
   logic              in_ack;
   logic              pkt_end;
   logic              line_state;
   logic              line_done;
   logic              clr_wr;

   assign clr_wr     = set_hit(set_i, SR_RX_CTRL + RX_CLEAR);
   assign pkt_end    = in.item.last || ((pkt_cnt + 1'b1) == spp_q);
   assign line_state = (state == HEADER) || (state == TIME_HI) ||
                       (state == TIME_LO) || (state == SAMPLE);
   assign line_done  = (line_ph == HS_REL) && !line_ack_i;

   assign in.ack     = in_ack;
   assign line_req_o = (line_ph == HS_REQ);

   // Item stays stable until we ack it, so time lines read it directly
   always_comb begin
      next_line = '0;
      case (state)
         HEADER: begin
            next_line.sof  = 1'b1;
            next_line.data = {seq_q, spp_q};
         end
         TIME_HI: next_line.data = in.item.ts[TIME_W-1:SET_DATA_W];
         TIME_LO: next_line.data = in.item.ts[SET_DATA_W-1:0];
         SAMPLE: begin
            next_line.eof  = pkt_end;
            next_line.data = in.item.data;
         end
         default: ;
      endcase
   end

   //////////////////////////////////////////////////
   // Line output handshake
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         line_ph <= HS_IDLE;
      end else begin
         case (line_ph)
            HS_IDLE: if (line_state) line_ph <= HS_REQ;
            HS_REQ:  if (line_ack_i) line_ph <= HS_REL;
            HS_REL:  if (!line_ack_i) line_ph <= HS_IDLE;
            default: line_ph <= HS_IDLE;
         endcase
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (line_ph == HS_IDLE && line_state) line_o <= next_line;
   end

   //////////////////////////////////////////////////
   // Packet sequencing
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state   <= IDLE;
         in_ack  <= 1'b0;
         spp_q   <= SPP_RESET;
         seq_q   <= '0;
         pkt_cnt <= '0;
      end else begin
         if (set_hit(set_i, SR_RX_CTRL + RX_SPP)) spp_q <= set_i.data[HALF_W-1:0];

         case (state)
            IDLE:    if (in.req) state <= (pkt_cnt == '0) ? HEADER : SAMPLE;
            HEADER:  if (line_done) state <= TIME_HI;
            TIME_HI: if (line_done) state <= TIME_LO;
            TIME_LO: if (line_done) state <= SAMPLE;
            SAMPLE: begin
               if (line_done) begin
                  in_ack <= 1'b1;   // Only now is the item consumed
                  state  <= WAIT_ACK;
                  if (pkt_end) begin
                     pkt_cnt <= '0;
                     seq_q   <= seq_q + 1'b1;
                  end else begin
                     pkt_cnt <= pkt_cnt + 1'b1;
                  end
               end
            end
            WAIT_ACK: begin
               if (!in.req) begin
                  in_ack <= 1'b0;
                  state  <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase

         if (clr_wr) begin
            seq_q   <= '0;
            pkt_cnt <= '0;
         end
      end
   end

endmodule

`default_nettype wire

// File: src/rx_core.sv
/* Receive path top level on the DSP clock. Settings writes, ADC samples and the
   line output are plain ports, blocks talk over four-phase streams inside. */
`default_nettype none

module rx_core (
   input  wire logic                          dsp_clk,
   input  wire logic                          por_rst,
   input  wire logic                          set_stb_i,
   input  wire logic [rx_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  wire logic [rx_pkg::SET_DATA_W-1:0] set_data_i,
   input  wire logic [rx_pkg::ADC_W-1:0]      adc_a_i,
   input  wire logic [rx_pkg::ADC_W-1:0]      adc_b_i,
   output rx_pkg::line_t                      line_o,
   output logic                               line_req_o,
   input  wire logic                          line_ack_i,
   output rx_pkg::vita_time_t                 vita_time_o,
   output logic                               run_o,
   output logic                               overrun_o
);
   import rx_pkg::*;

   set_bus_t set_bus;   // Seen by every block

   assign set_bus = '{stb: set_stb_i, addr: set_addr_i, data: set_data_i};

   rx_stream_if cap_stream ();
   rx_stream_if frm_stream ();

   vita_timer u_timer (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .set_i       (set_bus),
      .vita_time_o (vita_time_o)
   );

   rx_sample_capture u_capture (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .set_i       (set_bus),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .vita_time_i (vita_time_o),
      .out         (cap_stream.sender),
      .run_o       (run_o),
      .overrun_o   (overrun_o)
   );

   rx_sample_fifo u_fifo (
      .dsp_clk (dsp_clk),
      .por_rst (por_rst),
      .set_i   (set_bus),
      .in      (cap_stream.receiver),
      .out     (frm_stream.sender)
   );

   rx_vita_framer u_framer (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_i      (set_bus),
      .in         (frm_stream.receiver),
      .line_o     (line_o),
      .line_req_o (line_req_o),
      .line_ack_i (line_ack_i)
   );

endmodule

`default_nettype wire

// File: sim/tb_rx_core.sv
/* Random-stimulus testbench for rx_core. Loads the VITA time, runs bursts with
   fast and stalled line acks and checks each line against a reference model. */
`default_nettype none

module tb_rx_core;
   timeunit 1ns;
   timeprecision 1ps;
   import rx_pkg::*;

   localparam int MAX_CYCLES = 40000;   // Roughly twice the worst case of all bursts
   localparam vita_time_t T_LOAD = 64'h0000_0123_FFFF_FFF0;   // Low word wraps soon

   logic                  dsp_clk;
   logic                  por_rst;
   logic                  set_stb_i;
   logic [SET_ADDR_W-1:0] set_addr_i;
   logic [SET_DATA_W-1:0] set_data_i;
   logic [ADC_W-1:0]      adc_a_i;
   logic [ADC_W-1:0]      adc_b_i;
   line_t                 line_o;
   logic                  line_req_o;
   logic                  line_ack_i;
   vita_time_t            vita_time_o;
   logic                  run_o;
   logic                  overrun_o;

   int   seed      = 32'h3de9ce89;
   int   cycle_cnt = 0;
   int   ack_wait  = -1;     // Delay before ack (-1 while not drawn)
   logic hold_ack  = 1'b0;   // Stalls the line sink

   //////////////////////////////////////////////////
   // Reference model state
   logic [2*ADC_W-1:0] adc_log [vita_time_t];   // {adc_a, adc_b} by time
   vita_time_t         burst_t0;                // Time of the first strobe
   vita_time_t         next_ts;
   logic               run_seen = 1'b0;
   logic [HALF_W-1:0]  exp_seq  = '0;
   int                 spp;
   int                 decim;
   int                 burst_len;               // Samples expected at the output
   int                 burst_cnt;
   int                 pkt_cnt;
   int                 phase;                   // 0 header, 1 and 2 time, 3 samples
   logic               first_pkt;
   logic               burst_done;

   rx_core u_dut (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .line_o      (line_o),
      .line_req_o  (line_req_o),
      .line_ack_i  (line_ack_i),
      .vita_time_o (vita_time_o),
      .run_o       (run_o),
      .overrun_o   (overrun_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #50 dsp_clk = ~dsp_clk;
   end

   task automatic halt_sim();
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_line(input line_t got, input line_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s got sof=%b eof=%b data=%h, expected sof=%b eof=%b data=%h",
                  $time, what, got.sof, got.eof, got.data, exp.sof, exp.eof, exp.data);
         halt_sim();
      end
   endtask

   task automatic check_time(input vita_time_t got, input vita_time_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
         halt_sim();
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
         halt_sim();
      end
   endtask

   // Both channels sign-extended to 16 bits, a in the high half
   function automatic sample_t expect_sample(input logic [2*ADC_W-1:0] raw);
      logic [ADC_W-1:0] a;
      logic [ADC_W-1:0] b;
      a = raw[2*ADC_W-1:ADC_W];
      b = raw[ADC_W-1:0];
      return {{(HALF_W-ADC_W){a[ADC_W-1]}}, a, {(HALF_W-ADC_W){b[ADC_W-1]}}, b};
   endfunction

   //////////////////////////////////////////////////
   // Packet model, one call per accepted line
   task automatic take_line(input line_t l);
      line_t exp;
      exp = '0;
      case (phase)
         0: begin
            exp.sof  = 1'b1;
            exp.data = {exp_seq, HALF_W'(spp)};
            check_line(l, exp, "header line");
            if (first_pkt) next_ts = burst_t0;
            first_pkt = 1'b0;
            pkt_cnt   = 0;
            phase     = 1;
         end
         1: begin
            exp.data = next_ts[TIME_W-1:SET_DATA_W];
            check_line(l, exp, "time high line");
            phase = 2;
         end
         2: begin
            exp.data = next_ts[SET_DATA_W-1:0];
            check_line(l, exp, "time low line");
            phase = 3;
         end
         default: begin
            if (!adc_log.exists(next_ts)) begin
               $display("No ADC record for sample timestamp %h", next_ts);
               halt_sim();
            end else begin
               burst_cnt++;
               pkt_cnt++;
               exp.eof  = (pkt_cnt == spp) || (burst_cnt == burst_len);
               exp.data = expect_sample(adc_log[next_ts]);
               check_line(l, exp, "sample line");
               next_ts = next_ts + decim + 1;
               if (exp.eof) begin
                  phase   = 0;
                  exp_seq = exp_seq + 1'b1;
                  if (burst_cnt == burst_len) burst_done = 1'b1;
               end
            end
         end
      endcase
   endtask

   // ADC stimulus and line sink share one process, so seed use stays ordered
   always @(posedge dsp_clk) begin
      adc_a_i <= ADC_W'($random(seed));
      adc_b_i <= ADC_W'($random(seed));
      if (!por_rst) begin
         if (line_req_o && !line_ack_i && !hold_ack) begin
            if (ack_wait < 0) ack_wait = $unsigned($random(seed)) % 4;
            if (ack_wait == 0) begin
               take_line(line_o);
               line_ack_i <= 1'b1;
               ack_wait = -1;
            end else begin
               ack_wait--;
            end
         end else if (line_ack_i && !line_req_o) begin
            line_ack_i <= 1'b0;   // Req gone, finish the cycle
         end
      end
   end

   // ADC values of every cycle, keyed by the time of that cycle
   always @(posedge dsp_clk) begin
      if (!por_rst) begin
         adc_log[vita_time_o] = {adc_a_i, adc_b_i};
         if (run_o && !run_seen) burst_t0 = vita_time_o;   // First strobe is now
         run_seen = run_o;
      end
   end

   always @(posedge dsp_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         halt_sim();
      end
   end

   task automatic write_setting(input int unsigned addr, input logic [SET_DATA_W-1:0] data);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= SET_ADDR_W'(addr);
      set_data_i <= data;
      @(posedge dsp_clk);
      set_stb_i  <= 1'b0;
   endtask

   // One burst of n samples, stall holds line_ack_i low until the overrun
   task automatic run_burst(input int n, input int d, input int s, input logic stall);
      decim         = d;
      spp           = s;
      // A stalled sink passes a full FIFO plus the one item held in capture
      burst_len     = stall ? FIFO_DEPTH + 1 : n;
      burst_cnt     = 0;
      phase         = 0;
      first_pkt     = 1'b1;
      burst_done    = 1'b0;
      hold_ack      = stall;
      write_setting(SR_RX_CTRL + RX_DECIM, d);
      write_setting(SR_RX_CTRL + RX_SPP, s);
      write_setting(SR_RX_CTRL + RX_CMD, n);
      if (stall) begin
         do @(negedge dsp_clk); while (!overrun_o);
         check_flag(run_o, 1'b0, "run_o at overrun");
         hold_ack = 1'b0;
      end
      do @(negedge dsp_clk); while (!burst_done);
      while (line_req_o || line_ack_i) @(negedge dsp_clk);
      check_flag(run_o, 1'b0, "run_o after burst");
      check_flag(overrun_o, stall, "overrun_o after burst");
      if (burst_cnt != burst_len) begin
         $display("FAILED at %0t ns: burst of %0d delivered %0d samples, expected %0d",
                  $time, n, burst_cnt, burst_len);
         halt_sim();
      end
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   initial begin : main_seq
      int n;
      int d;
      int s;
      por_rst    <= 1'b1;
      set_stb_i  <= 1'b0;
      set_addr_i <= '0;
      set_data_i <= '0;
      adc_a_i    <= '0;
      adc_b_i    <= '0;
      line_ack_i <= 1'b0;
      repeat (2) @(posedge dsp_clk);
      por_rst <= 1'b0;
      @(negedge dsp_clk);
      check_flag(line_req_o, 1'b0, "line_req_o after reset");
      check_flag(run_o, 1'b0, "run_o after reset");
      check_flag(overrun_o, 1'b0, "overrun_o after reset");

      // Load the time with the high word first
      write_setting(SR_TIME64 + 0, T_LOAD[TIME_W-1:SET_DATA_W]);
      write_setting(SR_TIME64 + 1, T_LOAD[SET_DATA_W-1:0]);
      for (int i = 0; i < 32; i++) begin
         @(negedge dsp_clk);
         check_time(vita_time_o, T_LOAD + i, "vita_time_o");
      end

      // Random bursts with fast acks that the framer keeps up with
      for (int b = 0; b < 12; b++) begin
         n = 1 + $unsigned($random(seed)) % 48;
         d = 19 + $unsigned($random(seed)) % 12;
         s = 4 + $unsigned($random(seed)) % 5;
         run_burst(n, d, s, 1'b0);
      end

      run_burst(40, 6, 64, 1'b1);   // Back-pressure until overrun

      write_setting(SR_RX_CTRL + RX_CLEAR, 32'd1);
      @(negedge dsp_clk);
      check_flag(overrun_o, 1'b0, "overrun_o after clear");
      check_flag(run_o, 1'b0, "run_o after clear");
      exp_seq = '0;
      run_burst(20, 19, 6, 1'b0);

      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
src/rx_pkg.sv
src/rx_stream_if.sv
src/vita_timer.sv
src/rx_sample_capture.sv
src/rx_sample_fifo.sv
src/rx_vita_framer.sv
src/rx_core.sv
sim/tb_rx_core.sv

// File: Bender.yml
package:
  name: rx_core

dependencies: {}

sources:
  # Package first, then the interface and the RTL blocks, top level last
  - files:
      - src/rx_pkg.sv
      - src/rx_stream_if.sv
      - src/vita_timer.sv
      - src/rx_sample_capture.sv
      - src/rx_sample_fifo.sv
      - src/rx_vita_framer.sv
      - src/rx_core.sv
  # Testbench, top module tb_rx_core
  - target: simulation
    files:
      - sim/tb_rx_core.sv
